/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rx_link_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A crashed run counts as a failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Some tests failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
src/rx_link_pkg.sv
src/rx_cfg_if.sv
src/rx_cfg_regs.sv
src/rx_frame_decoder.sv
src/rx_addr_remap.sv
src/rx_distributor.sv
src/rx_packet_fifo.sv
src/rx_read_timer.sv
src/rx_link_top.sv
tests/rx_link_tb.sv

/* src/rx_addr_remap.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_addr_remap import rx_link_pkg::*; (
   input  wire logic          sys_clk,
   input  wire logic          rst,
   input  wire logic          in_valid,
   input  wire emesh_packet_t in_pkt,
   input  wire logic          in_rr,
   rx_cfg_if.user             cfg,
   output      logic          out_valid,
   output emesh_packet_t      out_pkt,
   output      logic          out_rr
);

   emesh_packet_t pkt_new;                      // Packet with rewritten address

   always_comb
   begin
      pkt_new = in_pkt;
      if (!in_rr)                               // Responses keep their address
      begin
         case (cfg.remap_mode)
            REMAP_STATIC:
               pkt_new.dstaddr[ADDR_W-1 -: ID_W] = (cfg.remap_sel & cfg.remap_pattern) |
                  (~cfg.remap_sel & in_pkt.dstaddr[ADDR_W-1 -: ID_W]);
            REMAP_DYNAMIC: pkt_new.dstaddr = in_pkt.dstaddr - cfg.remap_base;
            default: ;                          // NONE passes through
         endcase
      end
   end

   always_ff @(posedge sys_clk)
   begin
      if (rst)
         out_valid <= 1'b0;
      else
         out_valid <= in_valid;
   end

   always_ff @(posedge sys_clk)
   begin
      if (in_valid)
      begin
         out_pkt <= pkt_new;
         out_rr  <= in_rr;
      end
   end

endmodule

`default_nettype wire

/* src/rx_cfg_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface rx_cfg_if import rx_link_pkg::*; ();

   logic              rx_enable;                // Link receive gate
   remap_mode_e       remap_mode;
   logic [ID_W-1:0]   remap_sel;                // Bits of addr[31:20] to replace
   logic [ID_W-1:0]   remap_pattern;
   logic [ADDR_W-1:0] remap_base;               // Dynamic remap offset
   logic [1:0]        timer_cfg;                // 0 = timer off

   modport cfg (output rx_enable, remap_mode, remap_sel, remap_pattern, remap_base,
                timer_cfg);
   modport user (input rx_enable, remap_mode, remap_sel, remap_pattern, remap_base,
                 timer_cfg);

endinterface

`default_nettype wire

/* src/rx_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_cfg_regs import rx_link_pkg::*; (
   input  wire logic                 sys_clk,
   input  wire logic                 rst,
   input  wire logic                 mi_en,
   input  wire logic                 mi_we,
   input  wire logic [MI_ADDR_W-1:0] mi_addr,
   input  wire logic [DATA_W-1:0]    mi_din,
   output      logic [DATA_W-1:0]    mi_dout,
   input  wire logic                 timeout,
   input  wire logic                 wr_full,
   input  wire logic                 rd_full,
   input  wire logic                 rr_full,
   rx_cfg_if.cfg                     cfg
);

   logic              wr_sel;                   // Register write strobe
   logic              rd_sel;                   // Register read strobe
   logic [DATA_W-1:0] rd_data;                  // Readback mux output

   assign wr_sel = mi_en & mi_we;
   assign rd_sel = mi_en & ~mi_we;

   always_ff @(posedge sys_clk)
   begin
      if (rst)
      begin
         cfg.rx_enable     <= 1'b0;             // Link disabled out of reset
         cfg.remap_mode    <= REMAP_NONE;
         cfg.remap_sel     <= '0;
         cfg.remap_pattern <= '0;
         cfg.remap_base    <= '0;
         cfg.timer_cfg     <= 2'd0;
      end
      else if (wr_sel)
      begin
         case (mi_addr)
            REG_RX_CFG:
            begin
               cfg.rx_enable  <= mi_din[0];
               cfg.remap_mode <= remap_mode_e'(mi_din[2:1]);
               cfg.timer_cfg  <= mi_din[5:4];
            end
            REG_REMAP_CFG:
            begin
               cfg.remap_sel     <= mi_din[11:0];
               cfg.remap_pattern <= mi_din[27:16];
            end
            REG_REMAP_BASE: cfg.remap_base <= mi_din;
            default: ;                          // Status and holes ignore writes
         endcase
      end
   end

   always_comb
   begin
      case (mi_addr)
         REG_RX_CFG:     rd_data = {26'd0, cfg.timer_cfg, 1'b0, cfg.remap_mode, cfg.rx_enable};
         REG_REMAP_CFG:  rd_data = {4'd0, cfg.remap_pattern, 4'd0, cfg.remap_sel};
         REG_REMAP_BASE: rd_data = cfg.remap_base;
         REG_RX_STATUS:  rd_data = {28'd0, rr_full, rd_full, wr_full, timeout};
         default:        rd_data = '0;          // Unmapped reads zero
      endcase
   end

   always_ff @(posedge sys_clk)
   begin
      if (rst)
         mi_dout <= '0;
      else if (rd_sel)
         mi_dout <= rd_data;                    // One cycle read latency
   end

endmodule

`default_nettype wire

/* src/rx_distributor.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_distributor import rx_link_pkg::*; (
   input  wire logic          in_valid,
   input  wire emesh_packet_t in_pkt,
   input  wire logic          in_rr,
   input  wire logic          wr_full,          // Write queue almost full
   input  wire logic          rd_full,          // Read request queue almost full
   input  wire logic          rr_full,          // Read response queue almost full
   output      logic          wr_push,
   output      logic          rd_push,
   output      logic          rr_push,
   output emesh_packet_t      push_pkt,
   output      logic          wr_wait,
   output      logic          rd_wait
);

   logic is_write;                              // Plain write transaction
   logic is_read;                               // Read request

   assign is_write = in_pkt.write & ~in_rr;
   assign is_read  = ~in_pkt.write;

   // Exactly one queue takes each valid packet
   assign rr_push = in_valid & in_rr;
   assign wr_push = in_valid & is_write;
   assign rd_push = in_valid & is_read;

   assign push_pkt = in_pkt;                    // Shared write data for all queues

   // Writes and responses share the sender's write channel
   assign wr_wait = wr_full | rr_full;
   assign rd_wait = rd_full;

endmodule

`default_nettype wire

/* src/rx_frame_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_frame_decoder import rx_link_pkg::*; (
   input  wire logic       sys_clk,
   input  wire logic       rst,
   input  wire logic       rx_frame,
   input  wire logic [7:0] rx_data,
   rx_cfg_if.user          cfg,
   output      logic       pkt_valid,
   output emesh_packet_t   pkt,
   output      logic       is_rr
);

   logic [BYTE_CNT_W-1:0] byte_cnt;             // Bytes taken in current frame
   logic [PACKET_W-9:0]   byte_sr;              // First 12 bytes, oldest on top
   logic [PACKET_W-1:0]   frame_word;           // Whole frame in arrival order
   logic                  take_byte;
   logic                  last_byte;

   assign take_byte  = rx_frame & cfg.rx_enable;
   assign last_byte  = take_byte & (byte_cnt == BYTE_CNT_W'(FRAME_BYTES - 1));
   assign frame_word = {byte_sr, rx_data};     // Header, dst, data, src

   always_ff @(posedge sys_clk)
   begin
      if (rst)
      begin
         byte_cnt  <= '0;
         pkt_valid <= 1'b0;
      end
      else
      begin
         pkt_valid <= last_byte;                // Single cycle strobe
         if (!take_byte || last_byte)
            byte_cnt <= '0;                     // Short frame or done, restart
         else
            byte_cnt <= byte_cnt + 1'b1;
      end
   end

   // Payload path, only qualified by pkt_valid
   always_ff @(posedge sys_clk)
   begin
      if (take_byte)
         byte_sr <= {byte_sr[PACKET_W-17:0], rx_data};
      if (last_byte)
      begin
         pkt.ctrlmode <= frame_word[103:100];
         pkt.datamode <= frame_word[99:98];
         pkt.write    <= frame_word[97];
         pkt.rsvd     <= frame_word[96];
         pkt.dstaddr  <= frame_word[95:64];    // MSB first on the wire
         pkt.data     <= frame_word[63:32];
         pkt.srcaddr  <= frame_word[31:0];
         // Write to our own ID is a returning read response
         is_rr        <= frame_word[97] & (frame_word[95:84] == CHIP_ID);
      end
   end

endmodule

`default_nettype wire

/* src/rx_link_pkg.sv */
`default_nettype none

package rx_link_pkg;

   localparam int ADDR_W      = 32;             // Mesh address width
   localparam int DATA_W      = 32;             // Mesh data width
   localparam int PACKET_W    = 104;            // Flattened transaction width
   localparam int FRAME_BYTES = 13;             // Link bytes per transaction
   localparam int BYTE_CNT_W  = 4;              // Enough for 0..12
   localparam int ID_W        = 12;             // Chip ID field width
   localparam int MI_ADDR_W   = 20;             // Register bus address width

   localparam logic [ID_W-1:0] CHIP_ID = 12'h800;  // Matched against dstaddr[31:20]

   // Register map, byte offsets on the MI bus
   localparam logic [MI_ADDR_W-1:0] REG_RX_CFG     = 20'h0;
   localparam logic [MI_ADDR_W-1:0] REG_REMAP_CFG  = 20'h4;
   localparam logic [MI_ADDR_W-1:0] REG_REMAP_BASE = 20'h8;
   localparam logic [MI_ADDR_W-1:0] REG_RX_STATUS  = 20'hC;  // Read only

   localparam int FIFO_DEPTH  = 8;              // Entries per queue
   localparam int FIFO_MARGIN = 3;              // Slack for frames in flight
   localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W  = FIFO_AW + 1;    // Occupancy 0..DEPTH

   localparam int TIMER_W = 11;                 // Holds up to 1024
   localparam logic [1:3][TIMER_W-1:0] TIMEOUT_LIMITS = '{11'd64, 11'd256, 11'd1024};

   typedef enum logic [1:0] {
      REMAP_NONE    = 2'd0,                     // Address untouched
      REMAP_STATIC  = 2'd1,                     // Pattern over selected bits
      REMAP_DYNAMIC = 2'd2                      // Subtract base
   } remap_mode_e;

   typedef struct packed {
      logic [ADDR_W-1:0] srcaddr;               // Return address for reads
      logic [DATA_W-1:0] data;
      logic [ADDR_W-1:0] dstaddr;
      logic [3:0]        ctrlmode;
      logic [1:0]        datamode;              // Access size
      logic              write;                 // 1 = write, 0 = read
      logic              rsvd;
   } emesh_packet_t;

endpackage

`default_nettype wire

/* src/rx_link_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_link_top import rx_link_pkg::*; (
   input  wire logic                 sys_clk,
   input  wire logic                 rst,
   input  wire logic                 rx_frame,
   input  wire logic [7:0]           rx_data,
   output      logic                 wr_wait,
   output      logic                 rd_wait,
   output      logic                 rxwr_valid,
   output emesh_packet_t             rxwr_packet,
   input  wire logic                 rxwr_ready,
   output      logic                 rxrd_valid,
   output emesh_packet_t             rxrd_packet,
   input  wire logic                 rxrd_ready,
   output      logic                 rxrr_valid,
   output emesh_packet_t             rxrr_packet,
   input  wire logic                 rxrr_ready,
   input  wire logic                 mi_en,
   input  wire logic                 mi_we,
   input  wire logic [MI_ADDR_W-1:0] mi_addr,
   input  wire logic [DATA_W-1:0]    mi_din,
   output      logic [DATA_W-1:0]    mi_dout,
   input  wire logic                 tx_read,
   output      logic                 timeout
);

   logic          dec_valid;                    // Decoder stage
   emesh_packet_t dec_pkt;
   logic          dec_rr;
   logic          rmp_valid;                    // Remap stage
   emesh_packet_t rmp_pkt;
   logic          rmp_rr;
   logic          wr_push;                      // Queue write strobes
   logic          rd_push;
   logic          rr_push;
   emesh_packet_t push_pkt;
   logic          wr_full;                      // Almost-full flags
   logic          rd_full;
   logic          rr_full;

   rx_cfg_if cfg_bus ();

   rx_cfg_regs u_cfg_regs (
      .sys_clk, .rst, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout, .timeout,
      .wr_full, .rd_full, .rr_full, .cfg (cfg_bus.cfg)
   );

   rx_frame_decoder u_decoder (
      .sys_clk, .rst, .rx_frame, .rx_data, .cfg (cfg_bus.user),
      .pkt_valid (dec_valid), .pkt (dec_pkt), .is_rr (dec_rr)
   );

   rx_addr_remap u_remap (
      .sys_clk, .rst, .in_valid (dec_valid), .in_pkt (dec_pkt), .in_rr (dec_rr),
      .cfg (cfg_bus.user), .out_valid (rmp_valid), .out_pkt (rmp_pkt), .out_rr (rmp_rr)
   );

   rx_distributor u_distributor (
      .in_valid (rmp_valid), .in_pkt (rmp_pkt), .in_rr (rmp_rr),
      .wr_full, .rd_full, .rr_full, .wr_push, .rd_push, .rr_push, .push_pkt,
      .wr_wait, .rd_wait
   );

   rx_packet_fifo u_wr_fifo (                   // Incoming writes
      .sys_clk, .rst, .push (wr_push), .push_pkt, .out_ready (rxwr_ready),
      .out_valid (rxwr_valid), .out_pkt (rxwr_packet), .almost_full (wr_full)
   );

   rx_packet_fifo u_rd_fifo (                   // Incoming read requests
      .sys_clk, .rst, .push (rd_push), .push_pkt, .out_ready (rxrd_ready),
      .out_valid (rxrd_valid), .out_pkt (rxrd_packet), .almost_full (rd_full)
   );

   rx_packet_fifo u_rr_fifo (                   // Responses to our reads
      .sys_clk, .rst, .push (rr_push), .push_pkt, .out_ready (rxrr_ready),
      .out_valid (rxrr_valid), .out_pkt (rxrr_packet), .almost_full (rr_full)
   );

   rx_read_timer u_timer (
      .sys_clk, .rst, .start (tx_read), .stop (rr_push), .cfg (cfg_bus.user), .timeout
   );

endmodule

`default_nettype wire

/* src/rx_packet_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_packet_fifo import rx_link_pkg::*; (
   input  wire logic          sys_clk,
   input  wire logic          rst,
   input  wire logic          push,
   input  wire emesh_packet_t push_pkt,
   input  wire logic          out_ready,
   output      logic          out_valid,
   output emesh_packet_t      out_pkt,
   output      logic          almost_full
);

   emesh_packet_t         mem [FIFO_DEPTH];     // Packet storage
   logic [FIFO_AW-1:0]    wr_ptr;
   logic [FIFO_AW-1:0]    rd_ptr;
   logic [FIFO_CNT_W-1:0] count;                // Occupancy
   logic                  do_push;
   logic                  do_pop;

   assign out_valid   = (count != '0);          // Head is shown ahead
   assign out_pkt     = mem[rd_ptr];
   assign do_pop      = out_valid & out_ready;
   assign do_push     = push & (count != FIFO_CNT_W'(FIFO_DEPTH));  // Never overwrite
   assign almost_full = (count >= FIFO_CNT_W'(FIFO_DEPTH - FIFO_MARGIN));

   always_ff @(posedge sys_clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_pkt;
   end

   always_ff @(posedge sys_clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;            // Wraps at power of two depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/rx_read_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_read_timer import rx_link_pkg::*; (
   input  wire logic sys_clk,
   input  wire logic rst,
   input  wire logic start,                     // Local read sent
   input  wire logic stop,                      // Response queued
   rx_cfg_if.user    cfg,
   output      logic timeout
);

   logic               running;
   logic [TIMER_W-1:0] count;
   logic [TIMER_W-1:0] limit;                   // Selected limit in cycles

   always_comb
   begin
      case (cfg.timer_cfg)
         2'd1:    limit = TIMEOUT_LIMITS[1];
         2'd2:    limit = TIMEOUT_LIMITS[2];
         2'd3:    limit = TIMEOUT_LIMITS[3];
         default: limit = '0;                   // Unused, timer off
      endcase
   end

   always_ff @(posedge sys_clk)
   begin
      if (rst)
      begin
         running <= 1'b0;
         count   <= '0;
         timeout <= 1'b0;
      end
      else if (start)
      begin
         running <= 1'b1;                       // New read rearms and clears flag
         count   <= '0;
         timeout <= 1'b0;
      end
      else if (stop)
      begin
         running <= 1'b0;
         count   <= '0;
      end
      else if (running && cfg.timer_cfg != 2'd0)
      begin
         if (count == limit - 1'b1)
         begin
            timeout <= 1'b1;                    // Sticky until next start
            running <= 1'b0;
         end
         else
            count <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* tests/rx_link_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_link_tb import rx_link_pkg::*; ();

   localparam int WAIT_LIMIT = 400;             // Cycles before a wait gives up

   logic                 sys_clk = 1'b0;
   logic                 rst, rx_frame, tx_read, timeout;
   logic [7:0]           rx_data;
   logic                 wr_wait, rd_wait;
   logic                 rxwr_valid, rxrd_valid, rxrr_valid;
   logic                 rxwr_ready, rxrd_ready, rxrr_ready;
   emesh_packet_t        rxwr_packet, rxrd_packet, rxrr_packet;
   logic                 mi_en, mi_we;
   logic [MI_ADDR_W-1:0] mi_addr;
   logic [DATA_W-1:0]    mi_din, mi_dout;

   emesh_packet_t exp_wr [$];                   // Per-queue scoreboard kept in send order
   emesh_packet_t exp_rd [$];
   emesh_packet_t exp_rr [$];
   int            errors, checks, tests, failed;
   logic          cfg_en;                       // Model of the programmed config
   remap_mode_e   cfg_mode;
   logic [11:0]   cfg_sel, cfg_pattern;
   logic [31:0]   cfg_base;

   rx_link_top dut_i (.*);

   always #50 sys_clk = ~sys_clk;               // 100 ns period

   // Head must hold until taken
   wr_hold: assert property (@(posedge sys_clk) disable iff (rst)
      rxwr_valid && !rxwr_ready |=> rxwr_valid && $stable(rxwr_packet))
   else
   begin
      errors++;
      $display("mismatch at %0t: write queue head moved while stalled", $time);
   end
   rd_hold: assert property (@(posedge sys_clk) disable iff (rst)
      rxrd_valid && !rxrd_ready |=> rxrd_valid && $stable(rxrd_packet))
   else
   begin
      errors++;
      $display("mismatch at %0t: read queue head moved while stalled", $time);
   end
   rr_hold: assert property (@(posedge sys_clk) disable iff (rst)
      rxrr_valid && !rxrr_ready |=> rxrr_valid && $stable(rxrr_packet))
   else
   begin
      errors++;
      $display("mismatch at %0t: response queue head moved while stalled", $time);
   end

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_packet(input string name, input emesh_packet_t got,
                                 input emesh_packet_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("mismatch at %0t: %s queue got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic unexpected_packet(input string name);
      errors++;
      $display("The %s queue put out a packet that was never sent, at %0t", name, $time);
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("Gave up waiting for %s at %0t", what, $time);
   endtask

   // Transfers happen on valid and ready at the rising edge
   always @(posedge sys_clk)
   begin
      if (!rst && rxwr_valid && rxwr_ready)
      begin
         if (exp_wr.size() == 0)
            unexpected_packet("write");
         else
            compare_packet("write", rxwr_packet, exp_wr.pop_front());
      end
      if (!rst && rxrd_valid && rxrd_ready)
      begin
         if (exp_rd.size() == 0)
            unexpected_packet("read request");
         else
            compare_packet("read request", rxrd_packet, exp_rd.pop_front());
      end
      if (!rst && rxrr_valid && rxrr_ready)
      begin
         if (exp_rr.size() == 0)
            unexpected_packet("read response");
         else
            compare_packet("read response", rxrr_packet, exp_rr.pop_front());
      end
   end

   // Kind 0 write, 1 read, 2 response to a local read
   function automatic emesh_packet_t make_packet(input int kind);
      emesh_packet_t p;
      logic [31:0]   r;
      p.srcaddr  = $urandom;
      p.data     = $urandom;
      p.dstaddr  = $urandom;
      r          = $urandom;
      p.ctrlmode = r[3:0];
      p.datamode = r[5:4];
      p.rsvd     = r[6];
      p.write    = (kind != 1);
      if (kind == 2)
         p.dstaddr[31:20] = CHIP_ID;
      else if (kind == 0 && p.dstaddr[31:20] == CHIP_ID)
         p.dstaddr[30] = 1'b1;                  // Keep plain writes off the local ID
      return p;
   endfunction

   task automatic expect_packet(input emesh_packet_t p);
      emesh_packet_t e;
      e = p;
      if (cfg_en && p.write && p.dstaddr[31:20] == CHIP_ID)
         exp_rr.push_back(e);                   // Responses never remapped
      else if (cfg_en)
      begin
         if (cfg_mode == REMAP_STATIC)
         begin
            for (int b = 0; b < 12; b++)
            begin
               if (cfg_sel[b])
                  e.dstaddr[20+b] = cfg_pattern[b];  // Selected bits take the pattern
            end
         end
         else if (cfg_mode == REMAP_DYNAMIC)
            e.dstaddr = p.dstaddr - cfg_base;
         if (p.write)
            exp_wr.push_back(e);
         else
            exp_rd.push_back(e);
      end
   endtask

   // Returns one cycle after the last byte was driven
   task automatic send_frame(input emesh_packet_t p, input int nbytes);
      logic [PACKET_W-1:0] w;
      int                  n;
      w = {p.ctrlmode, p.datamode, p.write, p.rsvd, p.dstaddr, p.data, p.srcaddr};
      n = 0;
      while ((p.write ? wr_wait : rd_wait) && n < WAIT_LIMIT)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (n == WAIT_LIMIT)
         report_timeout("the link wait to drop");
      for (int i = 0; i < nbytes; i++)
      begin
         @(negedge sys_clk);
         rx_frame = 1'b1;
         rx_data  = w[PACKET_W-1-8*i -: 8];     // Header first, then MSB first
      end
      @(negedge sys_clk);
      rx_frame = 1'b0;
      if (nbytes == FRAME_BYTES)
         expect_packet(p);
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_wr.size() + exp_rd.size() + exp_rr.size() != 0 && n < WAIT_LIMIT)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (n == WAIT_LIMIT)
         report_timeout("all queues to drain");
      repeat (4) @(negedge sys_clk);            // Let any stray packet surface
   endtask

   task automatic reg_write(input logic [MI_ADDR_W-1:0] addr, input logic [31:0] data);
      @(negedge sys_clk);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = addr;
      mi_din  = data;
      @(negedge sys_clk);
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   task automatic reg_read(input logic [MI_ADDR_W-1:0] addr, output logic [31:0] data);
      @(negedge sys_clk);
      mi_en   = 1'b1;
      mi_addr = addr;
      @(negedge sys_clk);
      mi_en   = 1'b0;
      data    = mi_dout;                        // One cycle after the request
   endtask

   task automatic configure(input logic en, input remap_mode_e mode, input logic [1:0] timer,
                            input logic [11:0] sel, input logic [11:0] pattern,
                            input logic [31:0] base);
      reg_write(REG_REMAP_CFG, {4'd0, pattern, 4'd0, sel});
      reg_write(REG_REMAP_BASE, base);
      reg_write(REG_RX_CFG, {26'd0, timer, 1'b0, mode, en});
      cfg_en      = en;
      cfg_mode    = mode;
      cfg_sel     = sel;
      cfg_pattern = pattern;
      cfg_base    = base;
   endtask

   // Timeout in bit 0, wr_wait covers bits 1 and 3, rd_wait is bit 2
   task automatic check_status(input logic [31:0] status);
      compare_value("status against waits and timeout",
                    {29'd0, status[1] | status[3], status[2], status[0]},
                    {29'd0, wr_wait, rd_wait, timeout});
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests++;
      if (errors == errors_before)
         $display("test %0d %s: ok", tests, name);
      else
      begin
         failed++;
         $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
      end
   endtask

   initial
   begin
      logic [31:0] rd;
      logic [31:0] val;
      int          e0;
      int          n;
      void'($urandom(43));                      // Single seed for the run
      rst = 1'b1;
      rx_frame = 1'b0;
      rx_data = 8'd0;
      rxwr_ready = 1'b1;
      rxrd_ready = 1'b1;
      rxrr_ready = 1'b1;
      mi_en = 1'b0;
      mi_we = 1'b0;
      mi_addr = '0;
      mi_din = '0;
      tx_read = 1'b0;
      errors = 0;
      checks = 0;
      tests = 0;
      failed = 0;
      cfg_en = 1'b0;
      cfg_mode = REMAP_NONE;
      cfg_sel = '0;
      cfg_pattern = '0;
      cfg_base = '0;
      repeat (8) @(negedge sys_clk);            // Eight reset cycles
      rst = 1'b0;

      e0 = errors;
      compare_value("valids after reset", {29'd0, rxwr_valid, rxrd_valid, rxrr_valid}, 32'd0);
      compare_value("waits and timeout after reset", {29'd0, wr_wait, rd_wait, timeout}, 32'd0);
      for (int i = 0; i < 3; i++)
         send_frame(make_packet(i), FRAME_BYTES);   // Nothing expected with the receiver off
      wait_drained();
      finish_test("reset state and disabled receiver", e0);

      e0 = errors;
      configure(1'b1, REMAP_NONE, 2'd0, 12'h000, 12'h000, 32'h0);
      send_frame(make_packet(0), FRAME_BYTES);
      @(negedge sys_clk);
      compare_value("write valid 2 cycles after last byte", {31'd0, rxwr_valid}, 32'd0);
      @(negedge sys_clk);
      compare_value("write valid 3 cycles after last byte", {31'd0, rxwr_valid}, 32'd1);
      send_frame(make_packet(1), 7);            // Short frame dropped
      for (int i = 0; i < 24; i++)
         send_frame(make_packet(int'($urandom_range(2, 0))), FRAME_BYTES);
      wait_drained();
      finish_test("routing without remap", e0);

      e0 = errors;
      configure(1'b1, REMAP_STATIC, 2'd0, 12'hF0F, 12'hA5C, 32'h0);
      for (int i = 0; i < 12; i++)
         send_frame(make_packet(i % 3), FRAME_BYTES);
      wait_drained();
      configure(1'b1, REMAP_DYNAMIC, 2'd0, 12'h000, 12'h000, 32'h1234_5678);
      for (int i = 0; i < 12; i++)
         send_frame(make_packet(i % 3), FRAME_BYTES);
      wait_drained();
      finish_test("static and dynamic remap", e0);

      e0 = errors;
      configure(1'b1, REMAP_NONE, 2'd0, 12'h000, 12'h000, 32'h0);
      rxwr_ready = 1'b0;
      for (int i = 0; i < FIFO_DEPTH - FIFO_MARGIN; i++)
      begin
         compare_value("wr_wait below the margin", {31'd0, wr_wait}, 32'd0);
         send_frame(make_packet(0), FRAME_BYTES);
         send_frame(make_packet(1), FRAME_BYTES);   // Reads keep flowing
      end
      n = 0;
      while (exp_rd.size() != 0 && n < WAIT_LIMIT)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (n == WAIT_LIMIT)
         report_timeout("reads to pass the stalled writes");
      compare_value("wr_wait at the margin", {31'd0, wr_wait}, 32'd1);
      compare_value("rd_wait with writes stalled", {31'd0, rd_wait}, 32'd0);
      reg_read(REG_RX_STATUS, rd);
      compare_value("status with writes stalled", rd, 32'h0000_0002);  // Write flag only
      check_status(rd);
      rxwr_ready = 1'b1;
      wait_drained();
      compare_value("wr_wait after draining", {31'd0, wr_wait}, 32'd0);
      rxrd_ready = 1'b0;
      rxrr_ready = 1'b0;
      send_frame(make_packet(1), FRAME_BYTES);
      send_frame(make_packet(2), FRAME_BYTES);
      repeat (3) @(negedge sys_clk);            // Both heads held a while
      rxrd_ready = 1'b1;
      rxrr_ready = 1'b1;
      wait_drained();
      finish_test("back-pressure", e0);

      e0 = errors;
      reg_write(REG_RX_CFG, 32'h0000_0035);
      reg_read(REG_RX_CFG, rd);
      compare_value("RX_CFG read-back", rd, 32'h0000_0035);
      reg_write(REG_RX_CFG, 32'hFFFF_FFC9);     // Only enable is a defined bit here
      reg_read(REG_RX_CFG, rd);
      compare_value("RX_CFG undefined bits", rd, 32'h0000_0001);
      val = $urandom;
      reg_write(REG_REMAP_CFG, val);
      reg_read(REG_REMAP_CFG, rd);
      compare_value("REMAP_CFG read-back", rd, val & 32'h0FFF_0FFF);
      val = $urandom;
      reg_write(REG_REMAP_BASE, val);
      reg_read(REG_REMAP_BASE, rd);
      compare_value("REMAP_BASE read-back", rd, val);
      reg_write(REG_RX_STATUS, 32'hFFFF_FFFF);  // Read only
      reg_read(REG_RX_STATUS, rd);
      compare_value("status while idle", rd, 32'h0);
      check_status(rd);
      reg_read(20'h10, rd);
      compare_value("unmapped offset", rd, 32'h0);
      finish_test("register read-back", e0);

      e0 = errors;
      configure(1'b1, REMAP_NONE, 2'd1, 12'h000, 12'h000, 32'h0);
      @(negedge sys_clk);
      tx_read = 1'b1;
      @(negedge sys_clk);
      tx_read = 1'b0;
      n = 0;
      while (!timeout && n < WAIT_LIMIT)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (n == WAIT_LIMIT)
         report_timeout("the read timeout");
      compare_value("cycles from tx_read to timeout", n, 32'd64);
      reg_read(REG_RX_STATUS, rd);
      compare_value("status timeout bit", {31'd0, rd[0]}, 32'd1);
      check_status(rd);
      @(negedge sys_clk);
      tx_read = 1'b1;                           // New read clears the flag
      @(negedge sys_clk);
      tx_read = 1'b0;
      compare_value("timeout after new tx_read", {31'd0, timeout}, 32'd0);
      send_frame(make_packet(2), FRAME_BYTES);  // Answer well inside the limit
      n = 0;
      while (!timeout && n < 128)
      begin
         @(negedge sys_clk);
         n++;
      end
      compare_value("timeout with response in time", {31'd0, timeout}, 32'd0);
      wait_drained();
      finish_test("read timer", e0);

      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire
